// ==== source/blob_geom_pkg.sv ====
package blob_geom_pkg;

    // fixed frame size
    localparam int IMG_COLS = 32;
    localparam int IMG_ROWS = 24;

    // pixel position, wide enough for the frame above
    typedef logic [4:0] col_t;
    typedef logic [4:0] row_t;

endpackage

// ==== source/blob_label_pkg.sv ====
package blob_label_pkg;

    // label table, entry 0 is background
    localparam int LABEL_COUNT = 128;

    typedef logic [6:0]  label_t;
    typedef logic [11:0] size_t;   // pixels per label, whole frame fits
    typedef logic [7:0]  count_t;

    // conflict pair FIFO
    localparam int PAIR_DEPTH = 64;

    typedef logic [6:0] pair_ptr_t;   // msb is the wrap bit

    // credits handed to the sender after reset
    localparam int CREDITS = 4;

    typedef enum logic [2:0] {
        R_COLLECT,
        R_PAIR_FIND,
        R_FLATTEN,
        R_MAX,
        R_COUNT,
        R_REPORT,
        R_CLEAR
    } resolver_state_t;

endpackage

// ==== source/pixel_ingress.sv ====
`timescale 1ns/1ps

module pixel_ingress
    import blob_geom_pkg::*;
    import blob_label_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_pix_valid,
    input  logic i_pix,
    output logic o_credit,
    output logic o_pix_valid,
    output logic o_pix,
    output col_t o_col,
    output logic o_last,
    input  logic i_pix_ready
);

    logic [CREDITS-1:0]         fifo_mem;
    logic [$clog2(CREDITS)-1:0] wr_ptr_q;
    logic [$clog2(CREDITS)-1:0] rd_ptr_q;
    logic [$clog2(CREDITS):0]   fill_q;
    logic [$clog2(CREDITS):0]   owed_q;    // credits still to hand out
    logic                       credit_q;
    col_t                       col_q;
    row_t                       row_q;
    logic                       pop;

    assign pop         = o_pix_valid && i_pix_ready;
    assign o_pix_valid = (fill_q != '0);
    assign o_pix       = fifo_mem[rd_ptr_q];
    assign o_col       = col_q;
    assign o_last      = (col_q == col_t'(IMG_COLS - 1)) && (row_q == row_t'(IMG_ROWS - 1));
    assign o_credit    = credit_q;

    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            fifo_mem[wr_ptr_q] <= i_pix;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
            owed_q   <= ($clog2(CREDITS) + 1)'(CREDITS);   // initial burst
            credit_q <= 1'b0;
            col_q    <= '0;
            row_q    <= '0;
        end else begin
            if (i_pix_valid) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)         rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({i_pix_valid, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: ;
            endcase

            // a pop pays its own credit, the backlog drains one per cycle
            credit_q <= pop || (owed_q != '0);
            if (!pop && owed_q != '0) begin
                owed_q <= owed_q - 1'b1;
            end

            if (pop) begin
                if (col_q == col_t'(IMG_COLS - 1)) begin
                    col_q <= '0;
                    row_q <= o_last ? '0 : row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    // sender must never run past its credits
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pix_valid |-> (fill_q != ($clog2(CREDITS) + 1)'(CREDITS)));

endmodule

// ==== source/component_labeler.sv ====
`timescale 1ns/1ps

module component_labeler
    import blob_geom_pkg::*;
    import blob_label_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_pix_valid,
    input  logic   i_pix,
    input  col_t   i_col,
    input  logic   i_last,
    output logic   o_pix_ready,
    input  logic   i_busy,
    output logic   o_lbl_valid,
    output label_t o_lbl,
    output logic   o_pair_valid,
    output label_t o_pair_a,
    output label_t o_pair_b,
    output logic   o_label_ovf,
    output logic   o_frame_end
);

    label_t line_buf [IMG_COLS];   // labels of the row above
    label_t left_q;
    label_t next_q;
    logic   first_row_q;
    logic   wait_q;                // frame done, busy not yet seen
    logic   ready_q;

    logic   take;
    label_t up_lbl;
    label_t left_lbl;
    label_t lo_lbl;
    label_t hi_lbl;
    label_t new_lbl;
    logic   need_new;
    logic   exhausted;
    logic   is_pair;

    assign take        = i_pix_valid && ready_q;
    assign o_pix_ready = ready_q;

    assign up_lbl    = first_row_q ? '0 : line_buf[i_col];
    assign left_lbl  = (i_col == '0) ? '0 : left_q;
    assign lo_lbl    = (up_lbl < left_lbl) ? up_lbl : left_lbl;
    assign hi_lbl    = (up_lbl < left_lbl) ? left_lbl : up_lbl;
    assign exhausted = (next_q == '0);   // counter wrapped past 127

    always_comb begin
        need_new = 1'b0;
        is_pair  = 1'b0;
        new_lbl  = '0;
        if (i_pix) begin
            if (up_lbl == '0 && left_lbl == '0) begin
                need_new = 1'b1;
                new_lbl  = next_q;   // reads 0 once exhausted
            end else if (up_lbl == '0) begin
                new_lbl = left_lbl;
            end else if (left_lbl == '0) begin
                new_lbl = up_lbl;
            end else begin
                new_lbl = lo_lbl;
                is_pair = (up_lbl != left_lbl);
            end
        end
    end

    // line buffer and payload
    always_ff @(posedge i_clk) begin
        if (take) begin
            line_buf[i_col] <= new_lbl;
            left_q          <= new_lbl;
        end
        o_lbl    <= new_lbl;
        o_pair_a <= lo_lbl;
        o_pair_b <= hi_lbl;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            next_q       <= label_t'(1);
            first_row_q  <= 1'b1;
            wait_q       <= 1'b0;
            ready_q      <= 1'b0;
            o_lbl_valid  <= 1'b0;
            o_pair_valid <= 1'b0;
            o_label_ovf  <= 1'b0;
            o_frame_end  <= 1'b0;
        end else begin
            if (take) begin
                if (i_last) begin
                    next_q      <= label_t'(1);   // fresh labels per frame
                    first_row_q <= 1'b1;
                end else begin
                    if (need_new && !exhausted) next_q <= next_q + 1'b1;
                    if (i_col == col_t'(IMG_COLS - 1)) first_row_q <= 1'b0;
                end
            end

            // hold off the next frame until the resolver has started
            if (take && i_last) begin
                wait_q <= 1'b1;
            end else if (i_busy) begin
                wait_q <= 1'b0;
            end
            ready_q <= !i_busy && !wait_q && !(take && i_last);

            o_lbl_valid  <= take && i_pix && (new_lbl != '0);
            o_pair_valid <= take && is_pair;
            o_label_ovf  <= take && need_new && exhausted;
            o_frame_end  <= take && i_last;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pair_valid |-> (o_pair_a != o_pair_b));

endmodule

// ==== source/equivalence_resolver.sv ====
`timescale 1ns/1ps

module equivalence_resolver
    import blob_label_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_lbl_valid,
    input  label_t i_lbl,
    input  logic   i_pair_valid,
    input  label_t i_pair_a,
    input  label_t i_pair_b,
    input  logic   i_label_ovf,
    input  logic   i_frame_end,
    output logic   o_busy,
    output logic   o_blob_valid,
    output count_t o_blob_count,
    output logic   o_overflow
);

    resolver_state_t state_q;

    size_t     size_tab   [LABEL_COUNT];
    label_t    parent_tab [LABEL_COUNT];   // 0 means root
    label_t    fifo_a     [PAIR_DEPTH];
    label_t    fifo_b     [PAIR_DEPTH];
    pair_ptr_t wr_ptr_q;
    pair_ptr_t rd_ptr_q;
    logic      fifo_empty;
    logic      fifo_full;

    label_t walk_a_q;
    label_t walk_b_q;
    logic   walk_q;      // a pair is being walked to its roots
    label_t idx_q;
    logic   idx_last;
    size_t  max_q;
    count_t cnt_q;
    logic   ovf_q;
    logic   busy_q;

    label_t walk_pa;
    label_t walk_pb;
    label_t flat_par;
    label_t flat_root;
    logic   par_we;
    label_t par_widx;
    label_t par_wval;

    assign fifo_empty = (wr_ptr_q == rd_ptr_q);
    assign fifo_full  = (wr_ptr_q[$clog2(PAIR_DEPTH)] != rd_ptr_q[$clog2(PAIR_DEPTH)])
                     && (wr_ptr_q[$clog2(PAIR_DEPTH)-1:0] == rd_ptr_q[$clog2(PAIR_DEPTH)-1:0]);

    assign idx_last = (idx_q == label_t'(LABEL_COUNT - 1));
    assign o_busy   = busy_q;

    assign walk_pa   = parent_tab[walk_a_q];
    assign walk_pb   = parent_tab[walk_b_q];
    assign flat_par  = parent_tab[idx_q];
    // lower entries are already flat
    assign flat_root = (parent_tab[flat_par] == '0) ? flat_par : parent_tab[flat_par];

    // link larger root under smaller, or point a label at its final root
    always_comb begin
        par_we   = 1'b0;
        par_widx = (walk_a_q < walk_b_q) ? walk_b_q : walk_a_q;
        par_wval = (walk_a_q < walk_b_q) ? walk_a_q : walk_b_q;
        if (state_q == R_PAIR_FIND) begin
            par_we = walk_q && walk_pa == '0 && walk_pb == '0 && walk_a_q != walk_b_q;
        end else if (state_q == R_FLATTEN) begin
            par_we   = (flat_par != '0);
            par_widx = idx_q;
            par_wval = flat_root;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == R_COLLECT && i_pair_valid && !fifo_full) begin
            fifo_a[wr_ptr_q[$clog2(PAIR_DEPTH)-1:0]] <= i_pair_a;
            fifo_b[wr_ptr_q[$clog2(PAIR_DEPTH)-1:0]] <= i_pair_b;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= R_COLLECT;
            for (int i = 0; i < LABEL_COUNT; i++) begin
                size_tab[i]   <= '0;
                parent_tab[i] <= '0;
            end
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            walk_a_q     <= '0;
            walk_b_q     <= '0;
            walk_q       <= 1'b0;
            idx_q        <= '0;
            max_q        <= '0;
            cnt_q        <= '0;
            ovf_q        <= 1'b0;
            busy_q       <= 1'b0;
            o_blob_valid <= 1'b0;
            o_blob_count <= '0;
            o_overflow   <= 1'b0;
        end else begin
            o_blob_valid <= 1'b0;
            if (par_we) parent_tab[par_widx] <= par_wval;

            case (state_q)
                R_COLLECT: begin
                    if (i_lbl_valid) size_tab[i_lbl] <= size_tab[i_lbl] + 1'b1;
                    if (i_pair_valid) begin
                        if (fifo_full) ovf_q <= 1'b1;
                        else           wr_ptr_q <= wr_ptr_q + 1'b1;
                    end
                    if (i_label_ovf) ovf_q <= 1'b1;
                    if (i_frame_end) begin
                        state_q <= R_PAIR_FIND;
                        busy_q  <= 1'b1;
                    end
                end
                R_PAIR_FIND: begin
                    if (walk_q) begin
                        // one step up each chain per cycle
                        if (walk_pa != '0) walk_a_q <= walk_pa;
                        if (walk_pb != '0) walk_b_q <= walk_pb;
                        if (walk_pa == '0 && walk_pb == '0) walk_q <= 1'b0;
                    end else if (fifo_empty) begin
                        state_q <= R_FLATTEN;
                    end else begin
                        walk_a_q <= fifo_a[rd_ptr_q[$clog2(PAIR_DEPTH)-1:0]];
                        walk_b_q <= fifo_b[rd_ptr_q[$clog2(PAIR_DEPTH)-1:0]];
                        rd_ptr_q <= rd_ptr_q + 1'b1;
                        walk_q   <= 1'b1;
                    end
                end
                R_FLATTEN: begin
                    if (flat_par != '0) begin
                        size_tab[flat_root] <= size_tab[flat_root] + size_tab[idx_q];
                        size_tab[idx_q]     <= '0;
                    end
                    idx_q <= idx_q + 1'b1;   // wraps to 0 for the next pass
                    if (idx_last) begin
                        state_q <= R_MAX;
                        max_q   <= '0;
                    end
                end
                R_MAX: begin
                    if (size_tab[idx_q] > max_q) max_q <= size_tab[idx_q];
                    idx_q <= idx_q + 1'b1;
                    if (idx_last) begin
                        state_q <= R_COUNT;
                        cnt_q   <= '0;
                    end
                end
                R_COUNT: begin
                    if (size_tab[idx_q] > (max_q >> 3)) cnt_q <= cnt_q + 1'b1;
                    idx_q <= idx_q + 1'b1;
                    if (idx_last) state_q <= R_REPORT;
                end
                R_REPORT: begin
                    o_blob_valid <= 1'b1;
                    o_blob_count <= cnt_q;
                    o_overflow   <= ovf_q;
                    state_q      <= R_CLEAR;
                end
                R_CLEAR: begin
                    size_tab[idx_q]   <= '0;
                    parent_tab[idx_q] <= '0;
                    idx_q             <= idx_q + 1'b1;
                    if (idx_last) begin
                        state_q <= R_COLLECT;
                        busy_q  <= 1'b0;
                        ovf_q   <= 1'b0;
                    end
                end
                default: state_q <= R_COLLECT;
            endcase
        end
    end

    // keeps the parent forest acyclic, flatten relies on it
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        par_we |-> (par_wval < par_widx));

endmodule

// ==== source/blob_counter_top.sv ====
`timescale 1ns/1ps

module blob_counter_top
    import blob_geom_pkg::*;
    import blob_label_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_pix_valid,
    input  logic   i_pix,
    output logic   o_credit,
    output logic   o_blob_valid,
    output count_t o_blob_count,
    output logic   o_overflow
);

    // ingress to labeler
    logic   pix_valid;
    logic   pix;
    col_t   col;
    logic   last;
    logic   pix_ready;

    // labeler to resolver
    logic   lbl_valid;
    label_t lbl;
    logic   pair_valid;
    label_t pair_a;
    label_t pair_b;
    logic   label_ovf;
    logic   frame_end;
    logic   busy;

    pixel_ingress u_ingress (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_credit    (o_credit),
        .o_pix_valid (pix_valid),
        .o_pix       (pix),
        .o_col       (col),
        .o_last      (last),
        .i_pix_ready (pix_ready)
    );

    component_labeler u_labeler (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pix_valid  (pix_valid),
        .i_pix        (pix),
        .i_col        (col),
        .i_last       (last),
        .o_pix_ready  (pix_ready),
        .i_busy       (busy),
        .o_lbl_valid  (lbl_valid),
        .o_lbl        (lbl),
        .o_pair_valid (pair_valid),
        .o_pair_a     (pair_a),
        .o_pair_b     (pair_b),
        .o_label_ovf  (label_ovf),
        .o_frame_end  (frame_end)
    );

    equivalence_resolver u_resolver (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_lbl_valid  (lbl_valid),
        .i_lbl        (lbl),
        .i_pair_valid (pair_valid),
        .i_pair_a     (pair_a),
        .i_pair_b     (pair_b),
        .i_label_ovf  (label_ovf),
        .i_frame_end  (frame_end),
        .o_busy       (busy),
        .o_blob_valid (o_blob_valid),
        .o_blob_count (o_blob_count),
        .o_overflow   (o_overflow)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;   // 20 ns period
    end

    // two cycles of reset, released away from the rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

// ==== testbench/blob_counter_tb.sv ====
`timescale 1ns/1ps

module blob_counter_tb
    import blob_geom_pkg::*;
    import blob_label_pkg::*;
();

    localparam int NPIX       = IMG_ROWS * IMG_COLS;
    localparam int WAIT_LIMIT = 20000;   // cycles, longest resolve plus margin

    logic   clk;
    logic   rst_n;
    logic   pix_valid;
    logic   pix;
    logic   credit;
    logic   blob_valid;
    count_t blob_count;
    logic   overflow;

    logic        frame_img [NPIX];   // raster order
    logic [31:0] lfsr_q;
    logic [8:0]  expected_q [$];     // {overflow, count} per frame in flight
    int          credits_earned;
    int          early_credits;
    int          transfers_seen;
    int          pix_sent;
    int          results_seen;
    int          frames_sent;
    int          error_count;
    int          timeout_count;
    int          waited;
    logic        hung;

    tb_clock_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    blob_counter_top dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_pix_valid  (pix_valid),
        .i_pix        (pix),
        .o_credit     (credit),
        .o_blob_valid (blob_valid),
        .o_blob_count (blob_count),
        .o_overflow   (overflow)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic logic take_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    task automatic fill_rect(input int r0, input int c0, input int r1, input int c1);
        for (int r = r0; r <= r1; r++) begin
            for (int c = c0; c <= c1; c++) frame_img[r * IMG_COLS + c] = 1'b1;
        end
    endtask

    task automatic clear_frame();
        for (int i = 0; i < NPIX; i++) frame_img[i] = 1'b0;
    endtask

    // density in sixteenths
    task automatic random_frame(input int thr);
        logic [3:0] v;
        for (int i = 0; i < NPIX; i++) begin
            v = '0;
            for (int b = 0; b < 4; b++) v = {v[2:0], take_bit()};
            frame_img[i] = (int'(v) < thr);
        end
    endtask

    // flood fill for the blob count, raster pass for labels and pairs
    function automatic logic [8:0] reference_result();
        int   lab   [NPIX];
        int   sizes [NPIX];
        int   stack [NPIX];
        logic seen  [NPIX];
        int   n_blobs, sp, p, q, r, c, up, left, next_lbl, n_pairs, max_size, blob_cnt;
        logic ovf;
        n_blobs = 0;
        for (int i = 0; i < NPIX; i++) seen[i] = 1'b0;
        for (int i = 0; i < NPIX; i++) begin
            if (frame_img[i] && !seen[i]) begin
                sizes[n_blobs] = 0;
                seen[i]  = 1'b1;
                stack[0] = i;
                sp = 1;
                while (sp > 0) begin
                    sp--;
                    p = stack[sp];
                    r = p / IMG_COLS;
                    c = p % IMG_COLS;
                    sizes[n_blobs]++;
                    for (int d = 0; d < 4; d++) begin
                        q = -1;
                        case (d)
                            0:       if (r > 0) q = p - IMG_COLS;
                            1:       if (r < IMG_ROWS - 1) q = p + IMG_COLS;
                            2:       if (c > 0) q = p - 1;
                            default: if (c < IMG_COLS - 1) q = p + 1;
                        endcase
                        if (q >= 0 && frame_img[q] && !seen[q]) begin
                            seen[q]   = 1'b1;
                            stack[sp] = q;
                            sp++;
                        end
                    end
                end
                n_blobs++;
            end
        end
        max_size = 0;
        for (int b = 0; b < n_blobs; b++) if (sizes[b] > max_size) max_size = sizes[b];
        blob_cnt = 0;
        for (int b = 0; b < n_blobs; b++) if (sizes[b] > (max_size >> 3)) blob_cnt++;

        next_lbl = 1;
        n_pairs  = 0;
        for (int i = 0; i < NPIX; i++) begin
            lab[i] = 0;
            if (frame_img[i]) begin
                up   = (i >= IMG_COLS) ? lab[i - IMG_COLS] : 0;
                left = (i % IMG_COLS != 0) ? lab[i - 1] : 0;
                if (up == 0 && left == 0) begin
                    lab[i] = next_lbl;
                    next_lbl++;
                end else if (up == 0) begin
                    lab[i] = left;
                end else if (left == 0) begin
                    lab[i] = up;
                end else begin
                    lab[i] = (up < left) ? up : left;
                    if (up != left) n_pairs++;
                end
            end
        end
        ovf = (next_lbl - 1 > LABEL_COUNT - 1) || (n_pairs > PAIR_DEPTH);
        return {ovf, count_t'(blob_cnt)};
    endfunction

    task automatic send_pixel(input logic value);
        int   wait_cnt;
        logic go;
        logic pause;
        wait_cnt = 0;
        go       = 1'b0;
        while (!go && !hung) begin
            @(negedge clk);
            pix_valid = 1'b0;
            pause     = take_bit();
            if ((credits_earned - pix_sent) > 0 && !pause) begin
                go = 1'b1;
            end else begin
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) begin
                    $display("timeout: no credit came back within %0d cycles", WAIT_LIMIT);
                    timeout_count++;
                    hung = 1'b1;
                end
            end
        end
        if (go) begin
            pix_valid = 1'b1;
            pix       = value;
            pix_sent++;
        end
    endtask

    task automatic send_frame();
        expected_q.push_back(reference_result());
        frames_sent++;
        for (int i = 0; i < NPIX; i++) send_pixel(frame_img[i]);
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int wait_cnt;
        wait_cnt = 0;
        while (!hung && results_seen < target) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                $display("timeout: blob result missing after %0d cycles", WAIT_LIMIT);
                timeout_count++;
                hung = 1'b1;
            end
        end
    endtask

    // credits, transfers and results, seen once per clock
    always @(posedge clk) begin : monitor
        logic [8:0] exp_res;
        if (rst_n) begin
            if (pix_valid) begin
                transfers_seen++;
            end
            if (credit) begin
                credits_earned++;
                if (transfers_seen == 0) early_credits++;
                if (credits_earned - transfers_seen > CREDITS) begin
                    $display("credit pulse at %0t hands out more than %0d credits",
                             $time, CREDITS);
                    error_count++;
                end
            end
            if (blob_valid) begin
                if (expected_q.size() == 0) begin
                    $display("result pulse at %0t with no frame pending", $time);
                    error_count++;
                end else begin
                    exp_res = expected_q.pop_front();
                    check_value("o_overflow", overflow, exp_res[8]);
                    if (!exp_res[8]) check_value("o_blob_count", blob_count, exp_res[7:0]);
                end
                results_seen++;
            end
        end
    end

    initial begin
        pix_valid     = 1'b0;
        pix           = 1'b0;
        lfsr_q        = 32'he786_2342;
        hung          = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        waited        = 0;
        while (rst_n !== 1'b1 && !hung) begin
            @(negedge clk);
            waited++;
            if (waited > 100) begin
                $display("timeout: reset was never released");
                timeout_count++;
                hung = 1'b1;
            end
        end

        // initial credit burst, nothing sent yet
        repeat (12) @(negedge clk);
        check_value("o_credit pulses", early_credits, CREDITS);

        clear_frame();
        send_frame();
        wait_results(frames_sent);
        fill_rect(0, 0, IMG_ROWS - 1, IMG_COLS - 1);
        send_frame();
        wait_results(frames_sent);

        // two U shapes, one nested into a W, plus dots and a 2x2 below the cut
        clear_frame();
        fill_rect(2, 2, 14, 3);
        fill_rect(2, 9, 14, 10);
        fill_rect(13, 2, 14, 10);
        fill_rect(5, 14, 20, 15);
        fill_rect(5, 20, 20, 21);
        fill_rect(5, 26, 20, 27);
        fill_rect(19, 14, 20, 27);
        fill_rect(22, 0, 22, 0);
        fill_rect(0, 31, 0, 31);
        fill_rect(21, 4, 22, 5);
        send_frame();
        wait_results(frames_sent);

        // stairs rising to the right, a diagonal and a comb closed at the bottom
        clear_frame();
        for (int k = 0; k < 10; k++) fill_rect(20 - 2 * k, 4 + k, 21, 4 + k);
        for (int r = 0; r < 8; r++) fill_rect(r, 24 + r, r, 24 + r);
        for (int t = 0; t < 3; t++) fill_rect(12, 22 + 3 * t, 22, 22 + 3 * t);
        fill_rect(23, 21, 23, 31);
        send_frame();
        wait_results(frames_sent);

        for (int k = 0; k < 10; k++) begin
            random_frame(1 + (k * 14) / 9);
            send_frame();
            wait_results(frames_sent);
        end

        // checkerboard runs out of labels
        for (int i = 0; i < NPIX; i++) frame_img[i] = ((i / IMG_COLS + i % IMG_COLS) % 2 == 0);
        send_frame();
        wait_results(frames_sent);

        // second frame queued while the first one resolves
        random_frame(14);
        send_frame();
        random_frame(2);
        send_frame();
        wait_results(frames_sent);

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== blob_counter.f ====
source/blob_geom_pkg.sv
source/blob_label_pkg.sv
source/pixel_ingress.sv
source/component_labeler.sv
source/equivalence_resolver.sv
source/blob_counter_top.sv
testbench/tb_clock_gen.sv
testbench/blob_counter_tb.sv

// ==== Bender.yml ====
package:
  name: blob_counter

sources:
  - source/blob_geom_pkg.sv
  - source/blob_label_pkg.sv
  - source/pixel_ingress.sv
  - source/component_labeler.sv
  - source/equivalence_resolver.sv
  - source/blob_counter_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/blob_counter_tb.sv
